// ==== mrd_pkg.sv ====
package mrd_pkg;

	// sample and accumulator widths
	parameter int SAMPLE_W  = 18;           // one real or imaginary sample
	parameter int ACC_W     = SAMPLE_W + 2; // room for a sum of four samples
	parameter int NUM_LANES = 4;            // complex lanes per strobe

	// worst-case word growth per mode, in bits
	parameter logic [1:0] GROWTH_R4 = 2'd3;
	parameter logic [1:0] GROWTH_R2 = 2'd2;

	// butterfly mode, travels with every item
	typedef enum logic {
		RADIX_2 = 1'b0, // two independent 2-point butterflies
		RADIX_4 = 1'b1  // one 4-point DFT
	} radix_e;

	// complex sample at the port width
	typedef struct packed {
		logic signed [SAMPLE_W-1:0] re;
		logic signed [SAMPLE_W-1:0] im;
	} cplx_t;

	// complex value at the internal width
	typedef struct packed {
		logic signed [ACC_W-1:0] re;
		logic signed [ACC_W-1:0] im;
	} cplx_acc_t;

	// per-item mode fields, copied forward through every stage
	typedef struct packed {
		radix_e     radix;
		logic       inverse; // 1 selects the inverse transform
		logic [3:0] exp;     // incoming block exponent
		logic [1:0] margin;  // headroom already present in the input
	} bfly_ctrl_t;

	typedef struct packed {
		cplx_t [NUM_LANES-1:0] lane;
		bfly_ctrl_t            ctrl;
	} bfly_in_t;

	// common stage-to-stage register format
	typedef struct packed {
		cplx_acc_t [NUM_LANES-1:0] lane;
		bfly_ctrl_t                ctrl;
	} stage_t;

	typedef struct packed {
		cplx_t [NUM_LANES-1:0] lane;
		logic [3:0]            exp; // outgoing block exponent
	} bfly_out_t;

endpackage

// ==== mrd_input_stage.sv ====
`timescale 1ns/10ps

module mrd_input_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_val_i,
	input  mrd_pkg::bfly_in_t din_i,
	output logic              s1_val_o,
	output mrd_pkg::stage_t   s1_o
);
	import mrd_pkg::*;

	// operands of the two first-level butterflies
	cplx_t pa0;
	cplx_t pa1;
	cplx_t pb0;
	cplx_t pb1;

	stage_t s1_d; // next register contents

	// widened complex sum
	function automatic cplx_acc_t cadd(
		input cplx_t a,
		input cplx_t b
	);
		cplx_acc_t r;
		r.re = ACC_W'(a.re) + ACC_W'(b.re);
		r.im = ACC_W'(a.im) + ACC_W'(b.im);
		return r;
	endfunction

	// widened complex difference
	function automatic cplx_acc_t csub(
		input cplx_t a,
		input cplx_t b
	);
		cplx_acc_t r;
		r.re = ACC_W'(a.re) - ACC_W'(b.re);
		r.im = ACC_W'(a.im) - ACC_W'(b.im);
		return r;
	endfunction

	// lane pairing depends on the mode of this item
	always_comb begin
		pa0 = din_i.lane[0];
		pb1 = din_i.lane[3];
		if (din_i.ctrl.radix == RADIX_4) begin
			pa1 = din_i.lane[2]; // even samples 0 and 2
			pb0 = din_i.lane[1]; // odd samples 1 and 3
		end else begin
			pa1 = din_i.lane[1]; // first 2-point pair
			pb0 = din_i.lane[2]; // second 2-point pair
		end
	end

	// lanes out are sum a, sum b, diff a, diff b
	always_comb begin
		s1_d.lane[0] = cadd(pa0, pa1);
		s1_d.lane[1] = cadd(pb0, pb1);
		s1_d.lane[2] = csub(pa0, pa1);
		s1_d.lane[3] = csub(pb0, pb1);
		s1_d.ctrl    = din_i.ctrl;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_val_o <= 1'b0;
		end else begin
			s1_val_o <= in_val_i;
		end
	end

	// payload only moves on a strobe
	always_ff @(posedge clk) begin
		if (in_val_i) begin
			s1_o <= s1_d;
		end
	end

endmodule

// ==== mrd_combine_stage.sv ====
`timescale 1ns/10ps

module mrd_combine_stage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            s1_val_i,
	input  mrd_pkg::stage_t s1_i,
	output logic            s2_val_o,
	output mrd_pkg::stage_t s2_o
);
	import mrd_pkg::*;

	cplx_acc_t sum_a;
	cplx_acc_t sum_b;
	cplx_acc_t dif_a;
	cplx_acc_t dif_b;
	cplx_acc_t rot_b; // dif_b times -j, or +j for the inverse

	stage_t s2_d;

	function automatic cplx_acc_t cadd(
		input cplx_acc_t a,
		input cplx_acc_t b
	);
		cplx_acc_t r;
		r.re = a.re + b.re;
		r.im = a.im + b.im;
		return r;
	endfunction

	function automatic cplx_acc_t csub(
		input cplx_acc_t a,
		input cplx_acc_t b
	);
		cplx_acc_t r;
		r.re = a.re - b.re;
		r.im = a.im - b.im;
		return r;
	endfunction

	assign sum_a = s1_i.lane[0];
	assign sum_b = s1_i.lane[1];
	assign dif_a = s1_i.lane[2];
	assign dif_b = s1_i.lane[3];

	// multiply by +-j is a swap of re and im plus one negation
	always_comb begin
		if (s1_i.ctrl.inverse) begin
			rot_b.re = -dif_b.im; // +j * b
			rot_b.im =  dif_b.re;
		end else begin
			rot_b.re =  dif_b.im; // -j * b
			rot_b.im = -dif_b.re;
		end
	end

	// radix-4 lanes out: X0, X2, X1, X3
	always_comb begin
		if (s1_i.ctrl.radix == RADIX_4) begin
			s2_d.lane[0] = cadd(sum_a, sum_b);
			s2_d.lane[1] = csub(sum_a, sum_b);
			s2_d.lane[2] = cadd(dif_a, rot_b);
			s2_d.lane[3] = csub(dif_a, rot_b);
		end else begin
			s2_d.lane = s1_i.lane; // 2-point results are already complete
		end
		s2_d.ctrl = s1_i.ctrl;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s2_val_o <= 1'b0;
		end else begin
			s2_val_o <= s1_val_i;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_val_i) begin
			s2_o <= s2_d;
		end
	end

endmodule

// ==== mrd_scale_stage.sv ====
`timescale 1ns/10ps

module mrd_scale_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               s2_val_i,
	input  mrd_pkg::stage_t    s2_i,
	output logic               out_val_o,
	output mrd_pkg::bfly_out_t dout_o
);
	import mrd_pkg::*;

	// source lane for each output lane
	// same map for both modes given the combine stage lane layout
	localparam int OUT_SEL [NUM_LANES] = '{0, 2, 1, 3};

	logic [1:0] growth; // worst case for this item's mode
	logic [1:0] wg;     // applied shift

	cplx_t [NUM_LANES-1:0] lane_d;
	cplx_t [NUM_LANES-1:0] lane_q;
	logic [3:0]            exp_q;

	// arithmetic shift right by sh, round half up, wrap to SAMPLE_W
	function automatic logic signed [SAMPLE_W-1:0] round_shift(
		input logic signed [ACC_W-1:0] v,
		input logic [1:0]              sh
	);
		logic signed [ACC_W:0] ext;
		logic signed [ACC_W:0] q;
		ext = {v, 1'b0};  // one guard bit below the lsb
		ext = ext >>> sh; // guard bit now holds the half weight
		q   = (ext >>> 1) + $signed({{ACC_W{1'b0}}, ext[0]});
		return q[SAMPLE_W-1:0];
	endfunction

	function automatic cplx_t round_cplx(
		input cplx_acc_t  v,
		input logic [1:0] sh
	);
		cplx_t r;
		r.re = round_shift(v.re, sh);
		r.im = round_shift(v.im, sh);
		return r;
	endfunction

	always_comb begin
		growth = (s2_i.ctrl.radix == RADIX_4) ? GROWTH_R4 : GROWTH_R2;
		// margin covers part of the growth, never a left shift
		if (growth >= s2_i.ctrl.margin) begin
			wg = growth - s2_i.ctrl.margin;
		end else begin
			wg = 2'd0;
		end
	end

	// natural output order
	always_comb begin
		for (int k = 0; k < NUM_LANES; k++) begin
			lane_d[k] = round_cplx(s2_i.lane[OUT_SEL[k]], wg);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_val_o <= 1'b0;
			exp_q     <= 4'd0;
		end else begin
			out_val_o <= s2_val_i;
			if (s2_val_i) begin
				exp_q <= s2_i.ctrl.exp + {2'b00, wg}; // wraps at 16
			end
		end
	end

	// results held until the next strobe
	always_ff @(posedge clk) begin
		if (s2_val_i) begin
			lane_q <= lane_d;
		end
	end

	assign dout_o.lane = lane_q;
	assign dout_o.exp  = exp_q;

endmodule

// ==== mrd_butterfly.sv ====
`timescale 1ns/10ps

module mrd_butterfly (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_val_i,
	input  mrd_pkg::bfly_in_t  din_i,
	output logic               out_val_o,
	output mrd_pkg::bfly_out_t dout_o
);
	import mrd_pkg::*;

	// first-level sums and differences
	logic   s1_val;
	stage_t s1;

	// finished butterfly values at full width
	logic   s2_val;
	stage_t s2;

	// stage 1, lane pairing and first butterfly level
	mrd_input_stage i_mrd_input_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_val_i (in_val_i),
		.din_i    (din_i),
		.s1_val_o (s1_val),
		.s1_o     (s1)
	);

	// stage 2, second level with the j rotation
	mrd_combine_stage i_mrd_combine_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.s1_val_i (s1_val),
		.s1_i     (s1),
		.s2_val_o (s2_val),
		.s2_o     (s2)
	);

	// stage 3, growth shift, rounding and exponent
	mrd_scale_stage i_mrd_scale_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.s2_val_i  (s2_val),
		.s2_i      (s2),
		.out_val_o (out_val_o),
		.dout_o    (dout_o)
	);

endmodule

// ==== tb_mrd_butterfly.sv ====
`timescale 1ns/10ps

module tb_mrd_butterfly;
	import mrd_pkg::*;

	localparam int CLK_NS      = 8;
	localparam int N_R4_FWD    = 40;
	localparam int N_R4_INV    = 40;
	localparam int N_R2        = 40;
	localparam int N_SWEEP     = 32; // 2 modes x 4 margins x 4 items
	localparam int N_MIX       = 64;
	localparam int TOTAL_ITEMS = N_R4_FWD + N_R4_INV + N_R2 + N_SWEEP + N_MIX;
	localparam int WATCHDOG_NS = TOTAL_ITEMS * CLK_NS + 100 * CLK_NS;

	logic      clk;
	logic      rst_n;
	logic      in_val;
	bfly_in_t  din;
	logic      out_val;
	bfly_out_t dout;

	integer seed = 32'h6678;
	int     cyc  = 0;    // rising edges seen so far
	int     chk_cnt  = 0;
	int     err_cnt  = 0;
	int     chk_base = 0;
	int     err_base = 0;

	bfly_out_t expect_q[$];
	int        cap_q[$]; // last rising edge before each strobe

	mrd_butterfly i_mrd_butterfly (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_val_i  (in_val),
		.din_i     (din),
		.out_val_o (out_val),
		.dout_o    (dout)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	task automatic check_val(input string name, input logic signed [31:0] got,
		input logic signed [31:0] want);
		chk_cnt++;
		if (got !== want) begin
			err_cnt++;
			$display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, want);
		end
	endtask

	// floor(v / 2^sh + 1/2) wrapped to SAMPLE_W bits
	function automatic logic [SAMPLE_W-1:0] round_half_up(input int v, input int sh);
		int t;
		t = (2 * v + (1 << sh)) >>> (sh + 1);
		return t[SAMPLE_W-1:0];
	endfunction

	function automatic bfly_out_t ref_bfly(input bfly_in_t d);
		bfly_out_t r;
		int xr[NUM_LANES];
		int xi[NUM_LANES];
		int yr[NUM_LANES];
		int yi[NUM_LANES];
		int growth;
		int sh;
		int m;
		for (int n = 0; n < NUM_LANES; n++) begin
			xr[n] = int'($signed(d.lane[n].re));
			xi[n] = int'($signed(d.lane[n].im));
		end
		if (d.ctrl.radix == RADIX_4) begin
			growth = int'(GROWTH_R4);
			for (int k = 0; k < NUM_LANES; k++) begin
				yr[k] = 0;
				yi[k] = 0;
				for (int n = 0; n < NUM_LANES; n++) begin
					m = (n * k) % 4;       // power of -j
					if (d.ctrl.inverse)
						m = (4 - m) % 4;   // (+j)^m equals (-j)^(4-m)
					case (m)
						0: begin
							yr[k] += xr[n];
							yi[k] += xi[n];
						end
						1: begin // times -j
							yr[k] += xi[n];
							yi[k] -= xr[n];
						end
						2: begin
							yr[k] -= xr[n];
							yi[k] -= xi[n];
						end
						default: begin // times +j
							yr[k] -= xi[n];
							yi[k] += xr[n];
						end
					endcase
				end
			end
		end else begin
			growth = int'(GROWTH_R2);
			for (int p = 0; p < 2; p++) begin
				yr[2*p]   = xr[2*p] + xr[2*p+1];
				yi[2*p]   = xi[2*p] + xi[2*p+1];
				yr[2*p+1] = xr[2*p] - xr[2*p+1];
				yi[2*p+1] = xi[2*p] - xi[2*p+1];
			end
		end
		sh = growth - int'(d.ctrl.margin);
		if (sh < 0)
			sh = 0; // margin larger than the growth
		for (int k = 0; k < NUM_LANES; k++) begin
			r.lane[k].re = round_half_up(yr[k], sh);
			r.lane[k].im = round_half_up(yi[k], sh);
		end
		r.exp = 4'(int'(d.ctrl.exp) + sh);
		return r;
	endfunction

	// one strobe with random samples and exponent
	task automatic send_item(input radix_e radix, input logic inv, input logic [1:0] mg);
		bfly_in_t   d;
		logic [31:0] rnd;
		for (int n = 0; n < NUM_LANES; n++) begin
			rnd = $random(seed);
			d.lane[n].re = rnd[SAMPLE_W-1:0];
			rnd = $random(seed);
			d.lane[n].im = rnd[SAMPLE_W-1:0];
		end
		rnd = $random(seed);
		d.ctrl.radix   = radix;
		d.ctrl.inverse = inv;
		d.ctrl.exp     = rnd[3:0];
		d.ctrl.margin  = mg;
		@(negedge clk);
		in_val = 1'b1;
		din    = d;
		expect_q.push_back(ref_bfly(d));
		cap_q.push_back(cyc);
	endtask

	task automatic end_test(input string name);
		@(negedge clk);
		in_val = 1'b0;
		while (expect_q.size() != 0)
			@(negedge clk);
		$display("%s done: %0d checks, %0d errors", name, chk_cnt - chk_base,
			err_cnt - err_base);
		chk_base = chk_cnt;
		err_base = err_cnt;
	endtask

	// compare on the falling edge where outputs are settled
	always @(negedge clk) begin
		bfly_out_t want;
		int        cap;
		if (rst_n && out_val) begin
			if (expect_q.size() == 0) begin
				err_cnt++;
				$display("output strobe at %0t without a matching input strobe", $time);
			end else begin
				want = expect_q.pop_front();
				cap  = cap_q.pop_front();
				check_val("latency", cyc - cap, 3);
				for (int k = 0; k < NUM_LANES; k++) begin
					check_val($sformatf("dout_o.lane[%0d].re", k),
						$signed(dout.lane[k].re), $signed(want.lane[k].re));
					check_val($sformatf("dout_o.lane[%0d].im", k),
						$signed(dout.lane[k].im), $signed(want.lane[k].im));
				end
				check_val("dout_o.exp", dout.exp, want.exp);
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, outputs still pending", $time);
		$display("test failed");
		$finish;
	end

	initial begin
		rst_n  = 1'b0;
		in_val = 1'b0;
		din    = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// nothing may come out while idle after reset
		repeat (8) begin
			@(negedge clk);
			check_val("out_val_o", out_val, 0);
			check_val("dout_o.exp", dout.exp, 0);
		end
		end_test("reset idle");

		for (int i = 0; i < N_R4_FWD; i++)
			send_item(RADIX_4, 1'b0, 2'd0);
		end_test("radix-4 forward");

		for (int i = 0; i < N_R4_INV; i++)
			send_item(RADIX_4, 1'b1, 2'(i % 4));
		end_test("radix-4 inverse");

		for (int i = 0; i < N_R2; i++)
			send_item(RADIX_2, 1'(i % 2), 2'd0);
		end_test("radix-2 pairs");

		for (int r = 0; r < 2; r++) begin
			for (int m = 0; m < 4; m++) begin
				for (int rep = 0; rep < N_SWEEP / 8; rep++)
					send_item(radix_e'(r[0]), rep[0], 2'(m));
			end
		end
		end_test("margin sweep");

		// mode fields differ from item to item
		for (int i = 0; i < N_MIX; i++)
			send_item(radix_e'(i[0]), i[1], 2'(i % 4));
		end_test("mixed back-to-back");

		$display("total: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
mrd_pkg.sv
mrd_input_stage.sv
mrd_combine_stage.sv
mrd_scale_stage.sv
mrd_butterfly.sv
tb_mrd_butterfly.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the butterfly testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_mrd_butterfly
BUILD_LOG=build.log
SIM_LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator is not installed or not on PATH"
	exit 1
fi

# compile
verilator --binary --timing -f filelist.f --top-module "$TOP" -o "V$TOP" \
	> "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build returned status $status"
	exit 1
fi

# run
"./obj_dir/V$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation returned status $status"
	exit 1
fi

# verdict comes from the log
if grep -qx "test passed" "$SIM_LOG"; then
	exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1
